// ==== all.f ====
design/rvv_cfg_pkg.sv
design/rvv_uop_pkg.sv
design/rvv_cmd_queue.sv
design/rvv_decode_unit.sv
design/rvv_decode_ctrl.sv
design/rvv_uop_queue.sv
design/rvv_decode_top.sv
verification/tb_clk_gen.sv
verification/tb_rvv_decode.sv

// ==== design/rvv_cfg_pkg.sv ====
package rvv_cfg_pkg;

  // decode width, uops per slot set and push lanes
  localparam int NUM_DE_UOP        = 4;
  localparam int NUM_DE_UOP_WIDTH  = 2;

  // uop index inside one command
  localparam int UOP_INDEX_WIDTH   = 3;

  // command queue sizing
  localparam int CQ_DEPTH          = 8;
  localparam int CQ_PTR_WIDTH      = $clog2(CQ_DEPTH);
  localparam int CQ_CNT_WIDTH      = CQ_PTR_WIDTH + 1;

  // uop queue sizing
  localparam int UQ_DEPTH          = 16;
  localparam int UQ_PTR_WIDTH      = $clog2(UQ_DEPTH);
  localparam int UQ_CNT_WIDTH      = UQ_PTR_WIDTH + 1;

  localparam int VREG_WIDTH        = 5;

endpackage

// ==== design/rvv_cmd_queue.sv ====
`timescale 1ns/10ps

module rvv_cmd_queue (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              cmd_push,
  input  rvv_uop_pkg::cmd_t cmd_data,
  output logic              cmd_full,
  output logic              pkg0_valid,
  output rvv_uop_pkg::cmd_t pkg0_data,
  output logic              pkg1_valid,
  output rvv_uop_pkg::cmd_t pkg1_data,
  input  logic              pop0,
  input  logic              pop1
);
  import rvv_cfg_pkg::*;
  import rvv_uop_pkg::*;

  cmd_t                    mem [CQ_DEPTH];
  logic [CQ_PTR_WIDTH-1:0] wr_ptr;
  logic [CQ_PTR_WIDTH-1:0] rd_ptr;
  logic [CQ_PTR_WIDTH-1:0] rd_ptr_next;
  logic [CQ_CNT_WIDTH-1:0] count;
  logic [CQ_CNT_WIDTH-1:0] pop_num;

  // second head entry wraps with the pointer
  assign rd_ptr_next = rd_ptr + CQ_PTR_WIDTH'(1);

  assign pkg0_valid  = count != '0;
  assign pkg1_valid  = count >= CQ_CNT_WIDTH'(2);
  assign pkg0_data   = mem[rd_ptr];
  assign pkg1_data   = mem[rd_ptr_next];
  assign cmd_full    = count == CQ_CNT_WIDTH'(CQ_DEPTH);

  assign pop_num     = CQ_CNT_WIDTH'(pop0) + CQ_CNT_WIDTH'(pop1);

  always_ff @(posedge clk) begin
    if (cmd_push) begin
      mem[wr_ptr] <= cmd_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (cmd_push) begin
        wr_ptr <= wr_ptr + CQ_PTR_WIDTH'(1);
      end
      // one or two commands retire per cycle
      rd_ptr <= rd_ptr + CQ_PTR_WIDTH'(pop_num);
      count  <= count + CQ_CNT_WIDTH'(cmd_push) - pop_num;
    end
  end

  // writer must honour cmd_full
  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
    cmd_push |-> !cmd_full);

  // controller only retires the next command together with the head
  a_pop1_needs_pop0: assert property (@(posedge clk) disable iff (!arst_n)
    pop1 |-> pop0 && pkg1_valid);

endmodule

// ==== design/rvv_decode_ctrl.sv ====
`timescale 1ns/10ps

module rvv_decode_ctrl (
  input  logic                                                clk,
  input  logic                                                arst_n,
  input  logic                                                pkg0_valid,
  input  logic [rvv_cfg_pkg::NUM_DE_UOP-1:0]                  unit0_uop_valid_de2uq,
  input  rvv_uop_pkg::uop_t [rvv_cfg_pkg::NUM_DE_UOP-1:0]     unit0_uop_de2uq,
  input  logic                                                pkg1_valid,
  input  logic [rvv_cfg_pkg::NUM_DE_UOP-1:0]                  unit1_uop_valid_de2uq,
  input  rvv_uop_pkg::uop_t [rvv_cfg_pkg::NUM_DE_UOP-1:0]     unit1_uop_de2uq,
  output logic [rvv_cfg_pkg::UOP_INDEX_WIDTH-1:0]             uop_index_remain,
  output logic                                                pop0,
  output logic                                                pop1,
  output logic                                                push0,
  output rvv_uop_pkg::uop_t                                   data0,
  output logic                                                push1,
  output rvv_uop_pkg::uop_t                                   data1,
  output logic                                                push2,
  output rvv_uop_pkg::uop_t                                   data2,
  output logic                                                push3,
  output rvv_uop_pkg::uop_t                                   data3,
  input  logic                                                fifo_full,
  input  logic                                                fifo_1left_to_full,
  input  logic                                                fifo_2left_to_full,
  input  logic                                                fifo_3left_to_full
);
  import rvv_cfg_pkg::*;
  import rvv_uop_pkg::*;

  logic [NUM_DE_UOP_WIDTH:0]   quantity;
  logic [NUM_DE_UOP-1:0]       unit1_fit;
  logic                        unit0_last;
  logic                        unit1_last;
  logic                        fifo_ready;
  logic [NUM_DE_UOP_WIDTH-1:0] unit1_sel  [NUM_DE_UOP];
  logic [NUM_DE_UOP-1:0]       lane_valid;
  uop_t                        lane_data  [NUM_DE_UOP];
  logic [NUM_DE_UOP-1:0]       push_vec;
  logic                        uop_index_clear;
  logic                        enable_unit0;
  logic                        enable_unit1;
  logic [UOP_INDEX_WIDTH-1:0]  uop_index_din;

  // valid unit0 slots, contiguous from slot 0
  always_comb begin
    quantity = '0;
    for (int k = 0; k < NUM_DE_UOP; k++) begin
      quantity = quantity + (NUM_DE_UOP_WIDTH+1)'(unit0_uop_valid_de2uq[k]);
    end
  end

  // unit1 slots that still fit behind the unit0 slots
  always_comb begin
    for (int j = 0; j < NUM_DE_UOP; j++) begin
      unit1_fit[j] = (j + int'(quantity)) < NUM_DE_UOP;
    end
  end

  always_comb begin
    unit0_last = 1'b0;
    unit1_last = 1'b0;
    for (int k = 0; k < NUM_DE_UOP; k++) begin
      unit0_last = unit0_last | (unit0_uop_valid_de2uq[k] & unit0_uop_de2uq[k].last_uop_valid);
      unit1_last = unit1_last |
                   (unit1_fit[k] & unit1_uop_valid_de2uq[k] & unit1_uop_de2uq[k].last_uop_valid);
    end
  end

  // lane k takes unit0 slot k, else unit1 slot k-quantity
  always_comb begin
    for (int k = 0; k < NUM_DE_UOP; k++) begin
      unit1_sel[k] = NUM_DE_UOP_WIDTH'(k - int'(quantity));
      if (k < int'(quantity)) begin
        lane_valid[k] = pkg0_valid & unit0_uop_valid_de2uq[k];
        lane_data[k]  = unit0_uop_de2uq[k];
      end else begin
        lane_valid[k] = pkg1_valid & unit1_uop_valid_de2uq[unit1_sel[k]];
        lane_data[k]  = unit1_uop_de2uq[unit1_sel[k]];
      end
    end
  end

  // four free entries needed
  assign fifo_ready = !(fifo_full | fifo_1left_to_full | fifo_2left_to_full | fifo_3left_to_full);

  assign push_vec = lane_valid & {NUM_DE_UOP{fifo_ready}};
  assign push0    = push_vec[0];
  assign push1    = push_vec[1];
  assign push2    = push_vec[2];
  assign push3    = push_vec[3];
  assign data0    = lane_data[0];
  assign data1    = lane_data[1];
  assign data2    = lane_data[2];
  assign data3    = lane_data[3];

  assign pop0 = pkg0_valid & unit0_last & fifo_ready;
  assign pop1 = pkg1_valid & unit1_last & pop0;

  // resume index
  assign uop_index_clear = (pop0 & !pkg1_valid) | pop1;
  // head not finished this cycle
  assign enable_unit0    = fifo_ready & pkg0_valid & !pop0;
  // head finished, next command only partly sent
  assign enable_unit1    = pop0 & pkg1_valid & !pop1;

  always_comb begin
    uop_index_din = uop_index_remain;
    if (enable_unit0) begin
      uop_index_din = uop_index_remain + UOP_INDEX_WIDTH'(NUM_DE_UOP);
    end else if (enable_unit1) begin
      uop_index_din = UOP_INDEX_WIDTH'(NUM_DE_UOP - int'(quantity));
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      uop_index_remain <= '0;
    end else if (uop_index_clear) begin
      uop_index_remain <= '0;
    end else if (enable_unit0 | enable_unit1) begin
      uop_index_remain <= uop_index_din;
    end
  end

  // pushes fill lanes from 0 upward, uop queue writes them in order
  a_push_contiguous: assert property (@(posedge clk) disable iff (!arst_n)
    ((push_vec + 1'b1) & push_vec) == '0);

  // resume index never runs past the head command's last uop
  a_resume_in_cmd: assert property (@(posedge clk) disable iff (!arst_n)
    pkg0_valid |-> unit0_uop_valid_de2uq[0]);

endmodule

// ==== design/rvv_decode_top.sv ====
`timescale 1ns/10ps

module rvv_decode_top (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              cmd_push,
  input  rvv_uop_pkg::cmd_t cmd_data,
  output logic              cmd_full,
  input  logic              uq_pop,
  output logic              uq_valid,
  output rvv_uop_pkg::uop_t uq_data
);
  import rvv_cfg_pkg::*;
  import rvv_uop_pkg::*;

  // command queue heads
  logic                       pkg0_valid;
  logic                       pkg1_valid;
  cmd_t                       pkg0_data;
  cmd_t                       pkg1_data;
  logic                       pop0;
  logic                       pop1;

  // decoded slot sets
  logic [NUM_DE_UOP-1:0]      unit0_uop_valid_de2uq;
  uop_t [NUM_DE_UOP-1:0]      unit0_uop_de2uq;
  logic [NUM_DE_UOP-1:0]      unit1_uop_valid_de2uq;
  uop_t [NUM_DE_UOP-1:0]      unit1_uop_de2uq;
  logic [UOP_INDEX_WIDTH-1:0] uop_index_remain;

  // push lanes and uop queue levels
  logic                       push0;
  logic                       push1;
  logic                       push2;
  logic                       push3;
  uop_t                       data0;
  uop_t                       data1;
  uop_t                       data2;
  uop_t                       data3;
  logic                       fifo_full;
  logic                       fifo_1left_to_full;
  logic                       fifo_2left_to_full;
  logic                       fifo_3left_to_full;

  rvv_cmd_queue i_cmd_queue (
    .clk        (clk),
    .arst_n     (arst_n),
    .cmd_push   (cmd_push),
    .cmd_data   (cmd_data),
    .cmd_full   (cmd_full),
    .pkg0_valid (pkg0_valid),
    .pkg0_data  (pkg0_data),
    .pkg1_valid (pkg1_valid),
    .pkg1_data  (pkg1_data),
    .pop0       (pop0),
    .pop1       (pop1)
  );

  rvv_decode_unit i_decode_unit (
    .pkg0_data             (pkg0_data),
    .pkg1_data             (pkg1_data),
    .uop_index_remain      (uop_index_remain),
    .unit0_uop_valid_de2uq (unit0_uop_valid_de2uq),
    .unit0_uop_de2uq       (unit0_uop_de2uq),
    .unit1_uop_valid_de2uq (unit1_uop_valid_de2uq),
    .unit1_uop_de2uq       (unit1_uop_de2uq)
  );

  rvv_decode_ctrl i_decode_ctrl (
    .clk                   (clk),
    .arst_n                (arst_n),
    .pkg0_valid            (pkg0_valid),
    .unit0_uop_valid_de2uq (unit0_uop_valid_de2uq),
    .unit0_uop_de2uq       (unit0_uop_de2uq),
    .pkg1_valid            (pkg1_valid),
    .unit1_uop_valid_de2uq (unit1_uop_valid_de2uq),
    .unit1_uop_de2uq       (unit1_uop_de2uq),
    .uop_index_remain      (uop_index_remain),
    .pop0                  (pop0),
    .pop1                  (pop1),
    .push0                 (push0),
    .data0                 (data0),
    .push1                 (push1),
    .data1                 (data1),
    .push2                 (push2),
    .data2                 (data2),
    .push3                 (push3),
    .data3                 (data3),
    .fifo_full             (fifo_full),
    .fifo_1left_to_full    (fifo_1left_to_full),
    .fifo_2left_to_full    (fifo_2left_to_full),
    .fifo_3left_to_full    (fifo_3left_to_full)
  );

  rvv_uop_queue i_uop_queue (
    .clk                (clk),
    .arst_n             (arst_n),
    .push0              (push0),
    .data0              (data0),
    .push1              (push1),
    .data1              (data1),
    .push2              (push2),
    .data2              (data2),
    .push3              (push3),
    .data3              (data3),
    .fifo_full          (fifo_full),
    .fifo_1left_to_full (fifo_1left_to_full),
    .fifo_2left_to_full (fifo_2left_to_full),
    .fifo_3left_to_full (fifo_3left_to_full),
    .uq_pop             (uq_pop),
    .uq_valid           (uq_valid),
    .uq_data            (uq_data)
  );

endmodule

// ==== design/rvv_decode_unit.sv ====
`timescale 1ns/10ps

module rvv_decode_unit (
  input  rvv_uop_pkg::cmd_t                                   pkg0_data,
  input  rvv_uop_pkg::cmd_t                                   pkg1_data,
  input  logic [rvv_cfg_pkg::UOP_INDEX_WIDTH-1:0]             uop_index_remain,
  output logic [rvv_cfg_pkg::NUM_DE_UOP-1:0]                  unit0_uop_valid_de2uq,
  output rvv_uop_pkg::uop_t [rvv_cfg_pkg::NUM_DE_UOP-1:0]     unit0_uop_de2uq,
  output logic [rvv_cfg_pkg::NUM_DE_UOP-1:0]                  unit1_uop_valid_de2uq,
  output rvv_uop_pkg::uop_t [rvv_cfg_pkg::NUM_DE_UOP-1:0]     unit1_uop_de2uq
);
  import rvv_cfg_pkg::*;
  import rvv_uop_pkg::*;

  cmd_t                       cmd        [2];
  logic [UOP_INDEX_WIDTH-1:0] start      [2];
  logic [NUM_DE_UOP-1:0]      slot_valid [2];
  uop_t [NUM_DE_UOP-1:0]      slot_uop   [2];

  // head resumes mid-command, next always starts at uop 0
  assign cmd[0]   = pkg0_data;
  assign cmd[1]   = pkg1_data;
  assign start[0] = uop_index_remain;
  assign start[1] = '0;

  genvar c, i;
  generate
    for (c = 0; c < 2; c++) begin : g_cmd
      for (i = 0; i < NUM_DE_UOP; i++) begin : g_slot
        // one extra bit so start+i cannot wrap past uop_cnt
        logic [UOP_INDEX_WIDTH:0] idx;

        assign idx = {1'b0, start[c]} + (UOP_INDEX_WIDTH+1)'(i);

        assign slot_valid[c][i] = idx <= {1'b0, cmd[c].uop_cnt};

        assign slot_uop[c][i] = '{
          opcode:         cmd[c].opcode,
          vd:             cmd[c].vd + VREG_WIDTH'(idx),
          vs:             cmd[c].vs + VREG_WIDTH'(idx),
          uop_index:      idx[UOP_INDEX_WIDTH-1:0],
          last_uop_valid: idx == {1'b0, cmd[c].uop_cnt}
        };
      end
    end
  endgenerate

  assign unit0_uop_valid_de2uq = slot_valid[0];
  assign unit0_uop_de2uq       = slot_uop[0];
  assign unit1_uop_valid_de2uq = slot_valid[1];
  assign unit1_uop_de2uq       = slot_uop[1];

endmodule

// ==== design/rvv_uop_pkg.sv ====
package rvv_uop_pkg;

  typedef enum logic [1:0] {
    OP_ADD,
    OP_SUB,
    OP_MUL,
    OP_MOV
  } opcode_e;

  // one instruction in the command queue
  // uop_cnt holds the number of uops minus one
  typedef struct packed {
    opcode_e                                   opcode;
    logic [rvv_cfg_pkg::VREG_WIDTH-1:0]        vd;
    logic [rvv_cfg_pkg::VREG_WIDTH-1:0]        vs;
    logic [rvv_cfg_pkg::UOP_INDEX_WIDTH-1:0]   uop_cnt;
  } cmd_t;

  // one micro-operation in the uop queue
  typedef struct packed {
    opcode_e                                   opcode;
    logic [rvv_cfg_pkg::VREG_WIDTH-1:0]        vd;
    logic [rvv_cfg_pkg::VREG_WIDTH-1:0]        vs;
    logic [rvv_cfg_pkg::UOP_INDEX_WIDTH-1:0]   uop_index;
    logic                                      last_uop_valid;
  } uop_t;

endpackage

// ==== design/rvv_uop_queue.sv ====
`timescale 1ns/10ps

module rvv_uop_queue (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              push0,
  input  rvv_uop_pkg::uop_t data0,
  input  logic              push1,
  input  rvv_uop_pkg::uop_t data1,
  input  logic              push2,
  input  rvv_uop_pkg::uop_t data2,
  input  logic              push3,
  input  rvv_uop_pkg::uop_t data3,
  output logic              fifo_full,
  output logic              fifo_1left_to_full,
  output logic              fifo_2left_to_full,
  output logic              fifo_3left_to_full,
  input  logic              uq_pop,
  output logic              uq_valid,
  output rvv_uop_pkg::uop_t uq_data
);
  import rvv_cfg_pkg::*;
  import rvv_uop_pkg::*;

  uop_t                    mem      [UQ_DEPTH];
  uop_t                    data_arr [NUM_DE_UOP];
  logic [NUM_DE_UOP-1:0]   push_vec;
  logic [UQ_PTR_WIDTH-1:0] wr_ptr;
  logic [UQ_PTR_WIDTH-1:0] rd_ptr;
  logic [UQ_CNT_WIDTH-1:0] count;
  logic [UQ_CNT_WIDTH-1:0] free;
  logic [UQ_CNT_WIDTH-1:0] push_num;
  logic                    rd_en;

  assign push_vec    = {push3, push2, push1, push0};
  assign data_arr[0] = data0;
  assign data_arr[1] = data1;
  assign data_arr[2] = data2;
  assign data_arr[3] = data3;

  always_comb begin
    push_num = '0;
    for (int k = 0; k < NUM_DE_UOP; k++) begin
      push_num = push_num + UQ_CNT_WIDTH'(push_vec[k]);
    end
  end

  assign rd_en    = uq_pop & uq_valid;
  assign uq_valid = count != '0;
  assign uq_data  = mem[rd_ptr];

  // free-space levels for the controller
  assign free               = UQ_CNT_WIDTH'(UQ_DEPTH) - count;
  assign fifo_full          = free == UQ_CNT_WIDTH'(0);
  assign fifo_1left_to_full = free == UQ_CNT_WIDTH'(1);
  assign fifo_2left_to_full = free == UQ_CNT_WIDTH'(2);
  assign fifo_3left_to_full = free == UQ_CNT_WIDTH'(3);

  // lane k lands k entries past the write pointer
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_DE_UOP; k++) begin
      if (push_vec[k]) begin
        mem[UQ_PTR_WIDTH'(wr_ptr + k)] <= data_arr[k];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + UQ_PTR_WIDTH'(push_num);
      rd_ptr <= rd_ptr + UQ_PTR_WIDTH'(rd_en);
      count  <= count + push_num - UQ_CNT_WIDTH'(rd_en);
    end
  end

  // controller must stop pushing before the buffer overflows
  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    count <= UQ_CNT_WIDTH'(UQ_DEPTH));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -j 0 --top-module tb_rvv_decode -f all.f \
  -o sim_rvv_decode > build.log 2>&1 \
  && ./obj_dir/sim_rvv_decode > sim.log 2>&1 \
  || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }
grep -qx "NO ERRORS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic arst_n
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reset held low for four rising edges
  initial begin
    arst_n = 1'b0;
    repeat (4) @(posedge clk);
    #10;
    arst_n = 1'b1;
  end

endmodule

// ==== verification/tb_rvv_decode.sv ====
`timescale 1ns/10ps

module tb_rvv_decode;
  import rvv_cfg_pkg::*;
  import rvv_uop_pkg::*;

  logic   clk;
  logic   arst_n;
  logic   cmd_push;
  cmd_t   cmd_data;
  logic   cmd_full;
  logic   uq_pop;
  logic   uq_valid;
  uop_t   uq_data;

  integer seed;
  int     errors;
  int     tests_passed;
  int     tests_failed;
  int     wait_cycles;
  uop_t   exp_q [$];

  tb_clk_gen i_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  rvv_decode_top i_dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .cmd_push (cmd_push),
    .cmd_data (cmd_data),
    .cmd_full (cmd_full),
    .uq_pop   (uq_pop),
    .uq_valid (uq_valid),
    .uq_data  (uq_data)
  );

  function int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed);
    r = r & 32'h7fffffff;
    rand_range = lo + (r % (hi - lo + 1));
  endfunction

  task compare_uop(input string name, input uop_t exp, input uop_t act);
    if (exp !== act) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task compare_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Fail %s expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  task compare_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("Fail %s expected %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  // drive one random command and expand it into the model
  task push_cmd(input int min_cnt, input int max_cnt, output int added);
    cmd_t c;
    uop_t u;
    c.opcode  = opcode_e'(rand_range(0, 3));
    c.vd      = VREG_WIDTH'(rand_range(0, 31));
    c.vs      = VREG_WIDTH'(rand_range(0, 31));
    c.uop_cnt = UOP_INDEX_WIDTH'(rand_range(min_cnt, max_cnt));
    cmd_data  = c;
    cmd_push  = 1'b1;
    for (int k = 0; k <= int'(c.uop_cnt); k++) begin
      u.opcode         = c.opcode;
      u.vd             = c.vd + VREG_WIDTH'(k);
      u.vs             = c.vs + VREG_WIDTH'(k);
      u.uop_index      = UOP_INDEX_WIDTH'(k);
      u.last_uop_valid = k == int'(c.uop_cnt);
      exp_q.push_back(u);
    end
    added = int'(c.uop_cnt) + 1;
  endtask

  // pushes n_cmds commands while popping, until the model and the uop queue are drained
  task run_traffic(input string name, input int n_cmds, input int min_cnt, input int max_cnt,
                   input int push_pct, input int pop_pct);
    int sent;
    int cycles;
    int received;
    int expected;
    int added;
    sent     = 0;
    cycles   = 0;
    received = 0;
    expected = exp_q.size();
    while ((sent < n_cmds || exp_q.size() != 0 || uq_valid) && cycles < 20000) begin
      @(posedge clk);
      #10;
      cycles++;
      cmd_push = 1'b0;
      uq_pop   = 1'b0;
      if (sent < n_cmds && !cmd_full && rand_range(0, 99) < push_pct) begin
        push_cmd(min_cnt, max_cnt, added);
        expected += added;
        sent++;
      end
      if (uq_valid && rand_range(0, 99) < pop_pct) begin
        uq_pop = 1'b1;
        if (exp_q.size() == 0) begin
          $display("%s: the DUT produced a uop that the model did not expect", name);
          errors++;
        end else begin
          compare_uop($sformatf("%s uop %0d", name, received), exp_q.pop_front(), uq_data);
        end
        received++;
      end
    end
    @(posedge clk);
    #10;
    cmd_push = 1'b0;
    uq_pop   = 1'b0;
    if (cycles >= 20000) begin
      $display("%s: timed out waiting for the uop stream to drain", name);
      errors++;
    end
    compare_count({name, " count"}, expected, received);
    compare_bit({name, " idle uq_valid"}, 1'b0, uq_valid);
  endtask

  // stall the reader and push until the command queue reports full
  task fill_until_full(input string name);
    int added;
    wait_cycles = 0;
    uq_pop      = 1'b0;
    while (!cmd_full && wait_cycles < 200) begin
      @(posedge clk);
      #10;
      wait_cycles++;
      cmd_push = 1'b0;
      if (!cmd_full) begin
        push_cmd(0, 7, added);
      end
    end
    cmd_push = 1'b0;
    if (!cmd_full) begin
      $display("%s: cmd_full never rose while the reader was stalled", name);
      errors++;
    end
    compare_bit({name, " cmd_full"}, 1'b1, cmd_full);
  endtask

  task report_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %s passed", name);
      tests_passed++;
    end else begin
      $display("test %s failed", name);
      tests_failed++;
    end
  endtask

  initial begin
    int err_before;
    seed         = 39908;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    cmd_push     = 1'b0;
    cmd_data     = '0;
    uq_pop       = 1'b0;

    wait_cycles = 0;
    while (arst_n !== 1'b1 && wait_cycles < 20) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (arst_n !== 1'b1) begin
      $display("reset was never released");
      errors++;
    end
    @(posedge clk);
    #10;

    err_before = errors;
    compare_bit("reset uq_valid", 1'b0, uq_valid);
    compare_bit("reset cmd_full", 1'b0, cmd_full);
    report_test("reset", err_before);

    err_before = errors;
    run_traffic("single_uop", 20, 0, 0, 100, 100);
    report_test("single_uop", err_before);

    err_before = errors;
    run_traffic("long_cmds", 20, 4, 7, 100, 100);
    report_test("long_cmds", err_before);

    // short and long mixed so commands end mid-group
    err_before = errors;
    run_traffic("mixed_cmds", 40, 0, 7, 100, 100);
    report_test("mixed_cmds", err_before);

    err_before = errors;
    fill_until_full("stall");
    run_traffic("stall_drain", 0, 0, 0, 0, 100);
    report_test("stall", err_before);

    err_before = errors;
    run_traffic("random", 200, 0, 7, 70, 60);
    report_test("random", err_before);

    $display("tests passed %0d, tests failed %0d, errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
